//--- list.f
mem_geom_pkg.sv
xfer_pkg.sv
valid_pipe.sv
lane_dual_ram.sv
unbalanced_ram.sv
wide_port_ctrl.sv
narrow_port_ctrl.sv
unbalanced_buffer_top.sv
unbalanced_buffer_assertions.sv
tb_unbalanced_buffer.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail line in the log.
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_unbalanced_buffer -f list.f -o sim_tb \
    || { echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 && sim_ok=1 || sim_ok=0
cat sim.log
[ "$sim_ok" -eq 1 ] && ! grep -q "=== FAIL ===" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb_unbalanced_buffer.sv
module tb_unbalanced_buffer;
    import mem_geom_pkg::*;
    import xfer_pkg::*;

    localparam int ACK_LIMIT = 40;  // Longest wait for one handshake phase, in cycles.
    // Preload, lane reads, lane writes, dual port, back-pressure and random mix.
    localparam int TOTAL_OPS = 64 + 20 + 4 + 32 + 4 + 200;

    logic         clkb;
    logic         arst_n;
    logic         wide_req;
    wide_cmd_t    wide_cmd;
    logic         wide_ack;
    wide_word_t   wide_rdata;
    logic         narrow_req;
    narrow_cmd_t  narrow_cmd;
    logic         narrow_ack;
    narrow_word_t narrow_rdata;

    wide_word_t   model [MEM_DEPTH];  // Expected contents, one entry per wide word.
    logic [31:0]  lfsr = 32'hce91;
    int           mismatch_count = 0;
    int           protocol_count = 0;

    unbalanced_buffer_top #(.OUT_REG(1), .MUX_LATENCY(2)) unbalanced_buffer_top_i (.*);

    initial clkb = 1'b0;
    always #4 clkb = ~clkb;

    initial begin  // Watchdog, 20 cycles per operation.
        #(TOTAL_OPS * 20 * 8);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] expected,
                                   input logic [63:0] actual);
        mismatch_count++;
        $display("MISMATCH at %0t: %s expected %h, got %h", $time, sig, expected, actual);
    endtask

    task automatic protocol_error(input string what);
        protocol_count++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    // One four-phase cycle on the wide client, req kept high for hold extra cycles.
    task automatic wide_xfer(input logic is_write, input wide_addr_t a, input wide_word_t d,
                             input int hold, output wide_word_t rd);
        int n;
        @(negedge clkb);
        if (wide_ack) protocol_error("wide ack is high while no request is pending");
        wide_cmd = '{write: is_write, addr: a, wdata: d};
        wide_req = 1'b1;
        for (n = 0; !wide_ack && n < ACK_LIMIT; n++) @(negedge clkb);
        if (!wide_ack) protocol_error("wide ack never rose");
        rd = wide_rdata;
        repeat (hold) begin
            @(negedge clkb);
            if (!wide_ack) protocol_error("wide ack fell while req was still high");
            if (wide_rdata !== rd) report_mismatch("wide_rdata", rd, wide_rdata);
        end
        wide_req = 1'b0;
        for (n = 0; wide_ack && n < ACK_LIMIT; n++) @(negedge clkb);
        if (wide_ack) protocol_error("wide ack stayed high after req dropped");
    endtask

    task automatic narrow_xfer(input logic is_write, input narrow_addr_t a,
                               input narrow_word_t d, output narrow_word_t rd);
        int n;
        @(negedge clkb);
        if (narrow_ack) protocol_error("narrow ack is high while no request is pending");
        narrow_cmd = '{write: is_write, addr: a, wdata: d};
        narrow_req = 1'b1;
        for (n = 0; !narrow_ack && n < ACK_LIMIT; n++) @(negedge clkb);
        if (!narrow_ack) protocol_error("narrow ack never rose");
        rd = narrow_rdata;
        narrow_req = 1'b0;
        for (n = 0; narrow_ack && n < ACK_LIMIT; n++) @(negedge clkb);
        if (narrow_ack) protocol_error("narrow ack stayed high after req dropped");
    endtask

    task automatic wide_write(input wide_addr_t a, input wide_word_t d);
        wide_word_t rd;
        wide_xfer(1'b1, a, d, 0, rd);
        model[a] = d;
    endtask

    task automatic wide_read(input wide_addr_t a, input int hold);
        wide_word_t rd;
        wide_xfer(1'b0, a, '0, hold, rd);
        if (rd !== model[a]) report_mismatch("wide_rdata", model[a], rd);
    endtask

    task automatic narrow_write(input wide_addr_t w, input lane_sel_t l, input narrow_word_t d);
        narrow_word_t rd;
        narrow_xfer(1'b1, {w, l}, d, rd);
        model[w][l*NARROW_WIDTH +: NARROW_WIDTH] = d;  // Only this lane changes.
    endtask

    task automatic narrow_read(input wide_addr_t w, input lane_sel_t l);
        narrow_word_t rd;
        narrow_word_t expected;
        expected = model[w][l*NARROW_WIDTH +: NARROW_WIDTH];
        narrow_xfer(1'b0, {w, l}, '0, rd);
        if (rd !== expected) report_mismatch("narrow_rdata", 64'(expected), 64'(rd));
    endtask

    task automatic check_reset_idle();
        repeat (8) begin
            @(negedge clkb);
            if (wide_ack || narrow_ack) protocol_error("ack high after reset without req");
        end
    endtask

    task automatic wide_to_lanes();
        wide_addr_t addrs [4];
        for (int i = 0; i < 4; i++) begin
            addrs[i] = wide_addr_t'(rand_bits(6));
            wide_write(addrs[i], rand_bits(64));
        end
        for (int i = 0; i < 16; i++) narrow_read(addrs[i / 4], lane_sel_t'(i % 4));
    endtask

    task automatic lanes_to_wide();
        wide_write(6'd10, 64'h0123_4567_89ab_cdef);
        narrow_write(6'd10, 2'd1, 16'hbeef);
        narrow_write(6'd10, 2'd3, 16'hcafe);
        wide_read(6'd10, 0);  // Lanes 0 and 2 keep the old data.
    endtask

    task automatic dual_port_traffic();
        wide_addr_t   wa;
        wide_addr_t   nw;
        lane_sel_t    nl;
        wide_word_t   wd;
        narrow_word_t nd;
        for (int i = 0; i < 8; i++) begin
            wa = wide_addr_t'(2 * i);       // Even words on the wide port.
            nw = wide_addr_t'(2 * i + 33);  // Odd words on the narrow port.
            nl = lane_sel_t'(rand_bits(2));
            wd = rand_bits(64);
            nd = narrow_word_t'(rand_bits(16));
            fork
                begin
                    wide_write(wa, wd);
                    wide_read(wa, 0);
                end
                begin
                    narrow_write(nw, nl, nd);
                    narrow_read(nw, nl);
                end
            join
        end
    endtask

    task automatic back_pressure();
        wide_write(6'd20, rand_bits(64));
        wide_write(6'd21, ~model[20]);
        wide_read(6'd20, 10);  // Req stays high, so ack and rdata must hold.
        wide_read(6'd21, 0);
    endtask

    task automatic random_mix();
        logic       on_wide;
        logic       is_write;
        wide_addr_t w;
        lane_sel_t  l;
        repeat (200) begin
            on_wide  = 1'(rand_bits(1));
            is_write = 1'(rand_bits(1));
            w        = wide_addr_t'(rand_bits(6));
            l        = lane_sel_t'(rand_bits(2));
            if (on_wide && is_write) wide_write(w, rand_bits(64));
            else if (on_wide) wide_read(w, 0);
            else if (is_write) narrow_write(w, l, narrow_word_t'(rand_bits(16)));
            else narrow_read(w, l);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        wide_req   = 1'b0;
        wide_cmd   = '0;
        narrow_req = 1'b0;
        narrow_cmd = '0;
        repeat (5) @(posedge clkb);
        @(negedge clkb);
        arst_n = 1'b1;
        check_reset_idle();
        // Memory has no reset, so give every word a known value first.
        for (int a = 0; a < MEM_DEPTH; a++) begin
            wide_write(wide_addr_t'(a), {4{2'b01, 6'(a), 2'b10, ~6'(a)}});
        end
        wide_to_lanes();
        lanes_to_wide();
        dual_port_traffic();
        back_pressure();
        random_mix();
        $display("Errors: %0d mismatches, %0d handshake", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- unbalanced_buffer_assertions.sv
module unbalanced_buffer_assertions (
    input logic clkb,
    input logic arst_n,
    input logic wide_req,
    input logic wide_ack,
    input logic wide_en,
    input logic narrow_req,
    input logic narrow_ack,
    input logic narrow_en
);

    logic wide_issued;  // Strobe already sent for the current req.
    logic narrow_issued;

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            wide_issued   <= 1'b0;
            narrow_issued <= 1'b0;
        end else begin
            wide_issued   <= wide_en || (wide_issued && wide_req);
            narrow_issued <= narrow_en || (narrow_issued && narrow_req);
        end
    end

    // Ack is a register, so req and the strobe are looked at on the edge that raised it.
    wide_ack_rise: assert property (@(posedge clkb) disable iff (!arst_n)
        $rose(wide_ack) |-> $past(wide_req && wide_issued))
        else $error("wide ack rose without req");
    wide_ack_hold: assert property (@(posedge clkb) disable iff (!arst_n)
        wide_ack && wide_req |=> wide_ack) else $error("wide ack fell while req high");
    wide_strobe_len: assert property (@(posedge clkb) disable iff (!arst_n)
        wide_en |=> !wide_en) else $error("wide strobe longer than one cycle");
    wide_strobe_once: assert property (@(posedge clkb) disable iff (!arst_n)
        wide_en |-> !wide_issued) else $error("second wide strobe for one req");

    narrow_ack_rise: assert property (@(posedge clkb) disable iff (!arst_n)
        $rose(narrow_ack) |-> $past(narrow_req && narrow_issued))
        else $error("narrow ack rose without req");
    narrow_ack_hold: assert property (@(posedge clkb) disable iff (!arst_n)
        narrow_ack && narrow_req |=> narrow_ack) else $error("narrow ack fell while req high");
    narrow_strobe_len: assert property (@(posedge clkb) disable iff (!arst_n)
        narrow_en |=> !narrow_en) else $error("narrow strobe longer than one cycle");
    narrow_strobe_once: assert property (@(posedge clkb) disable iff (!arst_n)
        narrow_en |-> !narrow_issued) else $error("second narrow strobe for one req");

endmodule

bind unbalanced_buffer_top unbalanced_buffer_assertions unbalanced_buffer_assertions_i (
    .clkb(clkb), .arst_n(arst_n),
    .wide_req(wide_req), .wide_ack(wide_ack), .wide_en(wide_en),
    .narrow_req(narrow_req), .narrow_ack(narrow_ack), .narrow_en(narrow_en)
);

//--- unbalanced_buffer_top.sv
module unbalanced_buffer_top #(
    parameter int OUT_REG     = 1,
    parameter int MUX_LATENCY = 1
) (
    input  logic                       clkb,
    input  logic                       arst_n,
    // Wide client.
    input  logic                       wide_req,
    input  xfer_pkg::wide_cmd_t        wide_cmd,
    output logic                       wide_ack,
    output mem_geom_pkg::wide_word_t   wide_rdata,
    // Narrow client.
    input  logic                       narrow_req,
    input  xfer_pkg::narrow_cmd_t      narrow_cmd,
    output logic                       narrow_ack,
    output mem_geom_pkg::narrow_word_t narrow_rdata
);
    import mem_geom_pkg::*;

    logic         wide_en, wide_we, wide_ram_rvalid;
    wide_addr_t   wide_addr;
    wide_word_t   wide_wdata, wide_ram_rdata;
    logic         narrow_en, narrow_we, narrow_ram_rvalid;
    narrow_addr_t narrow_addr;
    narrow_word_t narrow_wdata, narrow_ram_rdata;

    wide_port_ctrl wide_port_ctrl_i (
        .clkb(clkb), .arst_n(arst_n),
        .req(wide_req), .cmd(wide_cmd), .ack(wide_ack), .rdata(wide_rdata),
        .en(wide_en), .we(wide_we), .addr(wide_addr), .wdata(wide_wdata),
        .ram_rdata(wide_ram_rdata), .ram_rvalid(wide_ram_rvalid)
    );

    narrow_port_ctrl narrow_port_ctrl_i (
        .clkb(clkb), .arst_n(arst_n),
        .req(narrow_req), .cmd(narrow_cmd), .ack(narrow_ack), .rdata(narrow_rdata),
        .en(narrow_en), .we(narrow_we), .addr(narrow_addr), .wdata(narrow_wdata),
        .ram_rdata(narrow_ram_rdata), .ram_rvalid(narrow_ram_rvalid)
    );

    // Each port has its own controller, so there is no arbitration.
    unbalanced_ram #(.OUT_REG(OUT_REG), .MUX_LATENCY(MUX_LATENCY)) unbalanced_ram_i (
        .clkb(clkb), .arst_n(arst_n),
        .wide_en(wide_en), .wide_we(wide_we),
        .wide_addr(wide_addr), .wide_wdata(wide_wdata),
        .wide_rdata(wide_ram_rdata), .wide_rvalid(wide_ram_rvalid),
        .narrow_en(narrow_en), .narrow_we(narrow_we),
        .narrow_addr(narrow_addr), .narrow_wdata(narrow_wdata),
        .narrow_rdata(narrow_ram_rdata), .narrow_rvalid(narrow_ram_rvalid)
    );

endmodule

//--- narrow_port_ctrl.sv
module narrow_port_ctrl (
    input  logic                       clkb,
    input  logic                       arst_n,
    input  logic                       req,
    input  xfer_pkg::narrow_cmd_t      cmd,
    output logic                       ack,
    output mem_geom_pkg::narrow_word_t rdata,
    // Toward the RAM.
    output logic                       en,
    output logic                       we,
    output mem_geom_pkg::narrow_addr_t addr,
    output mem_geom_pkg::narrow_word_t wdata,
    input  mem_geom_pkg::narrow_word_t ram_rdata,
    input  logic                       ram_rvalid
);
    import mem_geom_pkg::*;
    import xfer_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_issue, st_wait_read, st_ack_high, st_ack_low
    } state_t;

    state_t       state;
    narrow_cmd_t  cmd_q;
    narrow_word_t rdata_q;

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle:      if (req) state <= st_issue;
                st_issue:     state <= st_wait_read;
                // Read wait depends on OUT_REG and MUX_LATENCY of the RAM.
                st_wait_read: if (cmd_q.write || ram_rvalid) begin
                    state <= st_ack_high;
                    ack   <= 1'b1;
                end
                st_ack_high:  if (!req) begin  // Held while the client keeps req.
                    state <= st_ack_low;
                    ack   <= 1'b0;
                end
                st_ack_low:   state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clkb) begin
        if (state == st_idle && req) cmd_q <= cmd;
        if (state == st_wait_read && ram_rvalid) rdata_q <= ram_rdata;
    end

    assign en    = (state == st_issue);
    assign we    = cmd_q.write;
    assign addr  = cmd_q.addr;
    assign wdata = cmd_q.wdata;
    assign rdata = rdata_q;  // Stays put until the next read.

endmodule

//--- wide_port_ctrl.sv
module wide_port_ctrl (
    input  logic                     clkb,
    input  logic                     arst_n,
    input  logic                     req,
    input  xfer_pkg::wide_cmd_t      cmd,
    output logic                     ack,
    output mem_geom_pkg::wide_word_t rdata,
    // Toward the RAM.
    output logic                     en,
    output logic                     we,
    output mem_geom_pkg::wide_addr_t addr,
    output mem_geom_pkg::wide_word_t wdata,
    input  mem_geom_pkg::wide_word_t ram_rdata,
    input  logic                     ram_rvalid
);
    import mem_geom_pkg::*;
    import xfer_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_issue, st_wait_read, st_ack_high, st_ack_low
    } state_t;

    state_t     state;
    wide_cmd_t  cmd_q;
    wide_word_t rdata_q;

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle:      if (req) state <= st_issue;  // New request.
                st_issue:     state <= st_wait_read;
                // A write only waits one cycle here.
                st_wait_read: if (cmd_q.write || ram_rvalid) begin
                    state <= st_ack_high;
                    ack   <= 1'b1;
                end
                st_ack_high:  if (!req) begin
                    state <= st_ack_low;
                    ack   <= 1'b0;
                end
                st_ack_low:   state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clkb) begin
        if (state == st_idle && req) cmd_q <= cmd;
        if (state == st_wait_read && ram_rvalid) rdata_q <= ram_rdata;
    end

    assign en    = (state == st_issue);  // One cycle per request.
    assign we    = cmd_q.write;
    assign addr  = cmd_q.addr;
    assign wdata = cmd_q.wdata;
    assign rdata = rdata_q;

endmodule

//--- unbalanced_ram.sv
module unbalanced_ram #(
    parameter int OUT_REG     = 0,
    parameter int MUX_LATENCY = 0
) (
    input  logic                       clkb,
    input  logic                       arst_n,
    // Wide side.
    input  logic                       wide_en,
    input  logic                       wide_we,
    input  mem_geom_pkg::wide_addr_t   wide_addr,
    input  mem_geom_pkg::wide_word_t   wide_wdata,
    output mem_geom_pkg::wide_word_t   wide_rdata,
    output logic                       wide_rvalid,
    // Narrow side.
    input  logic                       narrow_en,
    input  logic                       narrow_we,
    input  mem_geom_pkg::narrow_addr_t narrow_addr,
    input  mem_geom_pkg::narrow_word_t narrow_wdata,
    output mem_geom_pkg::narrow_word_t narrow_rdata,
    output logic                       narrow_rvalid
);
    import mem_geom_pkg::*;

    // Lane index must ride along until the memory read data shows up.
    localparam int LANE_DEPTH = 2 + OUT_REG;

    wide_addr_t   narrow_word;
    lane_sel_t    narrow_lane;

    // Registered narrow access.
    logic         b_en_q;
    lane_mask_t   b_lane_we_q;
    wide_addr_t   b_addr_q;
    wide_word_t   b_wdata_q;

    wide_word_t   b_rdata;
    logic         b_rvalid;
    lane_sel_t    lane_sr [LANE_DEPTH];
    narrow_word_t mux_data;

    assign narrow_word = narrow_addr[NARROW_ADDR_WIDTH-1 -: WIDE_ADDR_WIDTH];
    assign narrow_lane = narrow_addr[LANE_SEL_WIDTH-1:0];

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            b_en_q      <= 1'b0;
            b_lane_we_q <= '0;
        end else begin
            b_en_q      <= narrow_en;
            b_lane_we_q <= (narrow_en && narrow_we) ? lane_mask_t'(1) << narrow_lane : '0;
        end
    end

    // Same lane data on every lane, the mask picks the one that lands.
    always_ff @(posedge clkb) begin
        b_addr_q  <= narrow_word;
        b_wdata_q <= {LANES{narrow_wdata}};
    end

    // One entry per cycle, so overlapping reads each keep their own lane.
    always_ff @(posedge clkb) begin
        lane_sr[0] <= narrow_lane;
        for (int i = 1; i < LANE_DEPTH; i++) begin
            lane_sr[i] <= lane_sr[i-1];
        end
    end

    lane_dual_ram #(.OUT_REG(OUT_REG)) lane_dual_ram_i (
        .clkb     (clkb),
        .arst_n   (arst_n),
        .a_en     (wide_en),
        .a_we     (wide_we),
        .a_addr   (wide_addr),
        .a_wdata  (wide_wdata),
        .a_rdata  (wide_rdata),   // Wide data is not touched.
        .a_rvalid (wide_rvalid),
        .b_en     (b_en_q),
        .b_lane_we(b_lane_we_q),
        .b_addr   (b_addr_q),
        .b_wdata  (b_wdata_q),
        .b_rdata  (b_rdata),
        .b_rvalid (b_rvalid)
    );

    // Lane mux.
    assign mux_data = b_rdata[lane_sr[LANE_DEPTH-1]*NARROW_WIDTH +: NARROW_WIDTH];

    valid_pipe #(.data_t(narrow_word_t), .DEPTH(MUX_LATENCY)) mux_pipe_i (
        .clkb     (clkb),
        .arst_n   (arst_n),
        .in_valid (b_rvalid),
        .in_data  (mux_data),
        .out_valid(narrow_rvalid),
        .out_data (narrow_rdata)
    );

endmodule

//--- lane_dual_ram.sv
module lane_dual_ram #(
    parameter int OUT_REG = 0
) (
    input  logic                       clkb,
    input  logic                       arst_n,
    // Port a, whole words.
    input  logic                       a_en,
    input  logic                       a_we,
    input  mem_geom_pkg::wide_addr_t   a_addr,
    input  mem_geom_pkg::wide_word_t   a_wdata,
    output mem_geom_pkg::wide_word_t   a_rdata,
    output logic                       a_rvalid,
    // Port b, lane writes.
    input  logic                       b_en,
    input  mem_geom_pkg::lane_mask_t   b_lane_we,
    input  mem_geom_pkg::wide_addr_t   b_addr,
    input  mem_geom_pkg::wide_word_t   b_wdata,
    output mem_geom_pkg::wide_word_t   b_rdata,
    output logic                       b_rvalid
);
    import mem_geom_pkg::*;

    wide_word_t mem [MEM_DEPTH];
    wide_word_t a_raw;
    wide_word_t b_raw;
    logic       a_raw_valid;
    logic       b_raw_valid;

    // Both ports read first, so a read sees the word before this edge's write.
    always_ff @(posedge clkb) begin
        if (a_en) begin
            a_raw <= mem[a_addr];
            if (a_we) mem[a_addr] <= a_wdata;
        end
        if (b_en) begin
            b_raw <= mem[b_addr];
            for (int k = 0; k < LANES; k++) begin
                if (b_lane_we[k]) begin
                    mem[b_addr][k*NARROW_WIDTH +: NARROW_WIDTH] <=
                        b_wdata[k*NARROW_WIDTH +: NARROW_WIDTH];
                end
            end
        end
    end

    always_ff @(posedge clkb or negedge arst_n) begin
        if (!arst_n) begin
            a_raw_valid <= 1'b0;
            b_raw_valid <= 1'b0;
        end else begin
            a_raw_valid <= a_en && !a_we;
            b_raw_valid <= b_en && (b_lane_we == '0);  // No lane set is a read.
        end
    end

    valid_pipe #(.data_t(wide_word_t), .DEPTH(OUT_REG)) a_out_pipe_i (
        .clkb(clkb), .arst_n(arst_n),
        .in_valid(a_raw_valid), .in_data(a_raw),
        .out_valid(a_rvalid), .out_data(a_rdata)
    );

    valid_pipe #(.data_t(wide_word_t), .DEPTH(OUT_REG)) b_out_pipe_i (
        .clkb(clkb), .arst_n(arst_n),
        .in_valid(b_raw_valid), .in_data(b_raw),
        .out_valid(b_rvalid), .out_data(b_rdata)
    );

endmodule

//--- valid_pipe.sv
module valid_pipe #(
    parameter type data_t = logic,
    parameter int  DEPTH  = 1
) (
    input  logic  clkb,
    input  logic  arst_n,
    input  logic  in_valid,
    input  data_t in_data,
    output logic  out_valid,
    output data_t out_data
);

    if (DEPTH == 0) begin : g_pass
        assign out_valid = in_valid;  // No stages.
        assign out_data  = in_data;
    end else begin : g_pipe
        logic [DEPTH-1:0] valid_sr;
        data_t            data_sr [DEPTH];

        always_ff @(posedge clkb or negedge arst_n) begin
            if (!arst_n) begin
                valid_sr <= '0;
            end else begin
                valid_sr[0] <= in_valid;
                for (int i = 1; i < DEPTH; i++) begin
                    valid_sr[i] <= valid_sr[i-1];
                end
            end
        end

        always_ff @(posedge clkb) begin
            data_sr[0] <= in_data;
            for (int i = 1; i < DEPTH; i++) begin
                data_sr[i] <= data_sr[i-1];
            end
        end

        assign out_valid = valid_sr[DEPTH-1];
        assign out_data  = data_sr[DEPTH-1];
    end

endmodule

//--- xfer_pkg.sv
package xfer_pkg;

    // Wide client request, 71 bits.
    typedef struct packed {
        logic                     write;  // 1 = write, 0 = read.
        mem_geom_pkg::wide_addr_t addr;
        mem_geom_pkg::wide_word_t wdata;
    } wide_cmd_t;

    // Narrow client request, 25 bits.
    // The address carries the lane in its low bits.
    typedef struct packed {
        logic                       write;  // 1 = write, 0 = read.
        mem_geom_pkg::narrow_addr_t addr;
        mem_geom_pkg::narrow_word_t wdata;
    } narrow_cmd_t;

endpackage

//--- mem_geom_pkg.sv
package mem_geom_pkg;

    // Wide side of the shared storage.
    localparam int WIDE_WIDTH      = 64;
    localparam int WIDE_ADDR_WIDTH = 6;
    localparam int MEM_DEPTH       = 2 ** WIDE_ADDR_WIDTH;  // 64 words.

    // Narrow side, four lanes per wide word.
    localparam int LANES             = 4;
    localparam int NARROW_WIDTH      = WIDE_WIDTH / LANES;
    localparam int LANE_SEL_WIDTH    = $clog2(LANES);
    localparam int NARROW_ADDR_WIDTH = WIDE_ADDR_WIDTH + LANE_SEL_WIDTH;

    // Data types.
    typedef logic [WIDE_WIDTH-1:0]   wide_word_t;
    typedef logic [NARROW_WIDTH-1:0] narrow_word_t;

    // Address fields.
    // A narrow address is the word index on top of the lane index.
    typedef logic [WIDE_ADDR_WIDTH-1:0]   wide_addr_t;
    typedef logic [NARROW_ADDR_WIDTH-1:0] narrow_addr_t;
    typedef logic [LANE_SEL_WIDTH-1:0]    lane_sel_t;

    // One write enable bit per lane, bit k covers bits k*16 upward.
    typedef logic [LANES-1:0] lane_mask_t;

endpackage
